//--- common/pix_mem_if.sv
// ------------------------------
// frame buffer access
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

// rd_data follows a read address by two clock edges,
// a write with we high lands on the same edge
interface pix_mem_if import pix_pkg::*; ();

    pix_addr_t rd_addr;
    pixel_t    rd_data;
    pix_addr_t wr_addr;
    pixel_t    wr_data;
    logic      we;

    modport user (
        output rd_addr,
        output wr_addr,
        output wr_data,
        output we,
        input  rd_data
    );

    modport memory (
        input  rd_addr,
        input  wr_addr,
        input  wr_data,
        input  we,
        output rd_data
    );

endinterface

`default_nettype wire

//--- common/pix_pkg.sv
// ------------------------------
// pixel filter types
// ------------------------------
`default_nettype none

`include "pix_settings.svh"

package pix_pkg;

    // rgb444, red in the top nibble
    typedef logic [11:0] pixel_t;

    typedef logic [`PIX_ADDR_W-1:0] pix_addr_t;

    typedef enum logic [1:0] {
        OP_GRAY   = 2'd0,
        OP_INVERT = 2'd1,
        OP_PASS   = 2'd2
    } filt_op_e;

    // engine sequencer phases
    typedef enum logic [2:0] {
        ST_IDLE   = 3'd0,
        ST_PRIME  = 3'd1,
        ST_STALL  = 3'd2,
        ST_STREAM = 3'd3,
        ST_DRAIN  = 3'd4,
        ST_DONE   = 3'd5
    } seq_state_e;

endpackage

`default_nettype wire

//--- common/pix_settings.svh
// ------------------------------
// pixel filter settings
// ------------------------------
`ifndef PIX_SETTINGS_SVH
`define PIX_SETTINGS_SVH

// frame buffer depth in pixels, 320x240
`define FRAME_PIXELS 76800
`define PIX_ADDR_W   17

// apb register byte offsets
`define REG_CTRL     5'h00
`define REG_STATUS   5'h04
`define REG_COUNT    5'h08
`define REG_HADDR    5'h0C
`define REG_HDATA    5'h10

`endif

//--- compile.f
+incdir+common
common/pix_pkg.sv
common/pix_mem_if.sv
hw/frame_buffer/frame_buffer.sv
hw/filter_engine/filter_sequencer.sv
hw/filter_engine/pixel_transform.sv
hw/apb_regs.sv
hw/image_filter_top.sv
dv/tb_image_filter.sv

//--- dv/tb_image_filter.sv
// ------------------------------
// image filter testbench
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "pix_settings.svh"

module tb_image_filter import pix_pkg::*; ();

    // only the low part of the frame is exercised
    localparam int TEST_PIX = 128;

    logic        clk_i;
    logic        rst_i;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [4:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    integer      seed;
    pixel_t      model [TEST_PIX];
    pixel_t      saved [TEST_PIX];

    image_filter_top dut0 (.*);

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_pixel(input pix_addr_t addr, input pixel_t got, input pixel_t exp);
        if (got !== exp) begin
            $display("error: pixel at 0x%h is 0x%h, expected 0x%h", addr, got, exp);
            abort_run();
        end
    endtask

    task automatic check_status(input logic got_busy, input logic got_done,
                                input logic exp_busy, input logic exp_done);
        if ({got_busy, got_done} !== {exp_busy, exp_done}) begin
            $display("error: status busy,done 0x%h, expected 0x%h",
                     {got_busy, got_done}, {exp_busy, exp_done});
            abort_run();
        end
    endtask

    task automatic check_err(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error: %s 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_addr(input pix_addr_t got, input pix_addr_t exp);
        if (got !== exp) begin
            $display("error: haddr 0x%h, expected 0x%h", got, exp);
            abort_run();
        end
    endtask

    // reference rules for one pixel
    function automatic pixel_t filter_pixel(input filt_op_e op, input pixel_t p);
        int         sum;
        logic [3:0] level;
        sum   = int'(p[11:8]) + int'(p[7:4]) + int'(p[3:0]);
        level = 4'(sum / 4);
        case (op)
            OP_GRAY:   return {level, level, level};
            OP_INVERT: return {4'(15 - int'(p[11:8])), 4'(15 - int'(p[7:4])),
                               4'(15 - int'(p[3:0]))};
            default:   return p;
        endcase
    endfunction

    // setup phase, then access phase until pready
    task automatic apb_access(input logic wr, input logic [4:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        int waits;
        @(posedge clk_i);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk_i);
        penable <= 1'b1;
        waits = 0;
        @(negedge clk_i);
        while (!pready) begin
            waits++;
            if (waits > 16) begin
                $display("timeout: no pready on apb access to 0x%h", addr);
                abort_run();
            end
            @(negedge clk_i);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk_i);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_write(input logic [4:0] addr, input logic [31:0] data, output logic err);
        logic [31:0] unused;
        apb_access(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input logic [4:0] addr, output logic [31:0] data, output logic err);
        apb_access(1'b0, addr, 32'd0, data, err);
    endtask

    task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
        logic err;
        apb_write(addr, data, err);
        check_err("pslverr", err, 1'b0);
    endtask

    task automatic write_pixels(input int first, input int len);
        write_reg(`REG_HADDR, 32'(first));
        for (int i = first; i < first + len; i++) begin
            write_reg(`REG_HDATA, {20'd0, model[i]});
        end
    endtask

    // reads the test region back and compares with the model
    task automatic read_region();
        logic [31:0] data;
        logic        err;
        write_reg(`REG_HADDR, 32'd0);
        for (int i = 0; i < TEST_PIX; i++) begin
            apb_read(`REG_HDATA, data, err);
            check_err("pslverr", err, 1'b0);
            check_pixel(pix_addr_t'(i), data[11:0], model[i]);
        end
    endtask

    task automatic reject_start(input logic [1:0] op_bits);
        logic [31:0] st;
        logic        err;
        apb_write(`REG_CTRL, {29'd0, op_bits, 1'b1}, err);
        check_err("pslverr", err, 1'b1);
        apb_read(`REG_STATUS, st, err);
        check_status(st[0], st[1], 1'b0, 1'b0);
    endtask

    task automatic start_pass(input filt_op_e op, input int count);
        logic [31:0] st;
        logic        err;
        write_reg(`REG_COUNT, 32'(count));
        apb_write(`REG_CTRL, {29'd0, op, 1'b1}, err);
        check_err("pslverr", err, 1'b0);
        // done from an earlier pass must be gone
        apb_read(`REG_STATUS, st, err);
        check_status(st[0], st[1], 1'b1, 1'b0);
    endtask

    task automatic wait_done();
        logic [31:0] st;
        logic        err;
        int          polls;
        polls = 0;
        apb_read(`REG_STATUS, st, err);
        while (st[0]) begin
            polls++;
            if (polls > 100) begin
                $display("timeout: filter pass still busy after %0d status polls", polls);
                abort_run();
            end
            apb_read(`REG_STATUS, st, err);
        end
        check_status(st[0], st[1], 1'b0, 1'b1);
    endtask

    // a finished pass rewrites the first count pixels
    task automatic apply_filter(input filt_op_e op, input int count);
        for (int i = 0; i < count; i++) begin
            model[i] = filter_pixel(op, model[i]);
        end
    endtask

    initial begin
        logic [31:0] data;
        logic        err;
        int          count;
        int          first;
        int          len;
        filt_op_e    op;
        seed    = 32'h2169_dc51;
        rst_i   = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (8) @(posedge clk_i);
        rst_i <= 1'b0;
        @(negedge clk_i);
        check_err("pready", pready, 1'b0);
        check_err("pslverr", pslverr, 1'b0);
        apb_read(`REG_STATUS, data, err);
        check_status(data[0], data[1], 1'b0, 1'b0);

        // host window with auto-increment
        for (int i = 0; i < TEST_PIX; i++) begin
            model[i] = pixel_t'($random(seed));
        end
        write_pixels(0, TEST_PIX);
        read_region();
        for (int r = 0; r < 4; r++) begin
            len   = 1 + ($random(seed) & 15);
            first = $random(seed) & 63;
            for (int i = first; i < first + len; i++) begin
                model[i] = pixel_t'($random(seed));
            end
            write_pixels(first, len);
            apb_read(`REG_HADDR, data, err);
            check_addr(data[`PIX_ADDR_W-1:0], pix_addr_t'(first + len));
            write_reg(`REG_HADDR, 32'(first));
            for (int i = first; i < first + len; i++) begin
                apb_read(`REG_HDATA, data, err);
                check_pixel(pix_addr_t'(i), data[11:0], model[i]);
            end
            apb_read(`REG_HADDR, data, err);
            check_addr(data[`PIX_ADDR_W-1:0], pix_addr_t'(first + len));
        end

        // bad count or opcode
        write_reg(`REG_COUNT, 32'd0);
        reject_start(2'd2);
        write_reg(`REG_COUNT, 32'(`FRAME_PIXELS + 1));
        reject_start(2'd0);
        write_reg(`REG_COUNT, 32'd8);
        reject_start(2'd3);
        read_region();

        count = 1 + ($random(seed) & 63);
        start_pass(OP_GRAY, count);
        wait_done();
        apply_filter(OP_GRAY, count);
        read_region();

        // double invert gives back the original frame
        saved = model;
        count = 1 + ($random(seed) & 63);
        start_pass(OP_INVERT, count);
        wait_done();
        apply_filter(OP_INVERT, count);
        read_region();
        start_pass(OP_INVERT, count);
        wait_done();
        model = saved;
        read_region();
        count = 1 + ($random(seed) & 63);
        start_pass(OP_PASS, count);
        wait_done();
        apply_filter(OP_PASS, count);
        read_region();

        // host accesses during a long pass
        count = 40 + ($random(seed) & 15);
        op    = filt_op_e'(2'({$random(seed)} % 3));
        start_pass(op, count);
        apb_read(`REG_HDATA, data, err);
        check_err("pslverr", err, 1'b1);
        apb_write(`REG_CTRL, 32'h1, err);
        check_err("pslverr", err, 1'b1);
        wait_done();
        apply_filter(op, count);
        read_region();

        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/apb_regs.sv
// ------------------------------
// apb register block
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "pix_settings.svh"

// CTRL   [0] start (write), [2:1] opcode
// STATUS [0] busy, [1] done
module apb_regs import pix_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [4:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic        start,
    output pix_addr_t   count,
    output filt_op_e    op,
    input  logic        busy,
    input  logic        done,
    pix_mem_if.user     host
);

    pix_addr_t   haddr;
    pix_addr_t   next_haddr;
    logic [1:0]  wait_cnt;
    logic        setup;
    logic        access_done;
    logic        eng_active;
    logic        hdata_sel;
    logic        start_req;
    logic        start_bad;
    logic [31:0] rd_mux;

    assign setup       = psel & ~penable;
    assign access_done = psel & penable & pready;
    // start pulse counts as busy, the sequencer has not seen it yet
    assign eng_active  = busy | start;
    assign hdata_sel   = (paddr == `REG_HDATA);
    assign start_req   = pwrite & (paddr == `REG_CTRL) & pwdata[0];
    assign start_bad   = eng_active | (count == '0)
                       | (count > pix_addr_t'(`FRAME_PIXELS)) | (pwdata[2:1] == 2'd3);
    assign next_haddr  = (haddr == pix_addr_t'(`FRAME_PIXELS - 1)) ? '0 : haddr + 1'b1;

    always_comb begin
        rd_mux = '0;
        case (paddr)
            `REG_CTRL:   rd_mux[2:1] = op;
            `REG_STATUS: rd_mux[1:0] = {done & ~start, eng_active};
            `REG_COUNT:  rd_mux[`PIX_ADDR_W-1:0] = count;
            `REG_HADDR:  rd_mux[`PIX_ADDR_W-1:0] = haddr;
            default:     rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            prdata   <= '0;
            pready   <= 1'b0;
            pslverr  <= 1'b0;
            wait_cnt <= '0;
            start    <= 1'b0;
            count    <= '0;
            op       <= OP_GRAY;
            haddr    <= '0;
        end else begin
            start <= 1'b0;
            if (setup) begin
                if (hdata_sel && !pwrite && !eng_active) begin
                    // RAM samples haddr on this edge
                    wait_cnt <= 2'd2;
                end else begin
                    pready  <= 1'b1;
                    pslverr <= (hdata_sel & eng_active) | (start_req & start_bad);
                    prdata  <= pwrite ? '0 : rd_mux;
                end
            end else if (wait_cnt != 2'd0) begin
                wait_cnt <= wait_cnt - 1'b1;
                if (wait_cnt == 2'd1) begin
                    pready <= 1'b1;
                    prdata <= {20'b0, host.rd_data};
                end
            end else if (access_done) begin
                pready  <= 1'b0;
                pslverr <= 1'b0;
                if (!pslverr) begin
                    if (hdata_sel) begin
                        haddr <= next_haddr;
                    end
                    if (pwrite) begin
                        case (paddr)
                            `REG_CTRL: begin
                                if (pwdata[0]) begin
                                    start <= 1'b1;
                                    op    <= filt_op_e'(pwdata[2:1]);
                                end
                            end
                            `REG_COUNT: count <= pwdata[`PIX_ADDR_W-1:0];
                            `REG_HADDR: haddr <= pwdata[`PIX_ADDR_W-1:0];
                            default: ;
                        endcase
                    end
                end
            end
        end
    end

    // host window, written on the completing edge
    assign host.rd_addr = haddr;
    assign host.wr_addr = haddr;
    assign host.wr_data = pwdata[11:0];
    assign host.we      = access_done & pwrite & hdata_sel & ~pslverr;

endmodule

`default_nettype wire

//--- hw/filter_engine/filter_sequencer.sv
// ------------------------------
// filter pass sequencer
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module filter_sequencer import pix_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_i,
    input  logic      start,
    input  pix_addr_t count,
    output logic      busy,
    output logic      done,
    pix_mem_if.user   mem
);

    seq_state_e state;
    pix_addr_t  rd_addr_q;
    pix_addr_t  last_addr_q;
    logic       rd_vld_q;
    // [0] newest, [2] is the write stage
    logic [2:0] vld_d;
    pix_addr_t  addr_d [3];

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            state       <= ST_IDLE;
            busy        <= 1'b0;
            done        <= 1'b0;
            rd_addr_q   <= '0;
            last_addr_q <= '0;
            rd_vld_q    <= 1'b0;
            vld_d       <= '0;
        end else begin
            vld_d <= {vld_d[1:0], rd_vld_q};

            // one read address per cycle until the last one
            if (rd_vld_q) begin
                if (rd_addr_q == last_addr_q) begin
                    rd_vld_q <= 1'b0;
                end else begin
                    rd_addr_q <= rd_addr_q + 1'b1;
                end
            end

            case (state)
                ST_IDLE, ST_DONE: begin
                    if (start) begin
                        state       <= ST_PRIME;
                        busy        <= 1'b1;
                        done        <= 1'b0;
                        rd_addr_q   <= '0;
                        last_addr_q <= count - 1'b1;
                        rd_vld_q    <= 1'b1;
                    end
                end
                // first address is in the RAM address stage
                ST_PRIME:  state <= ST_STALL;
                // waiting out the RAM output stage
                ST_STALL:  state <= ST_STREAM;
                ST_STREAM: begin
                    if (!rd_vld_q) begin
                        state <= ST_DRAIN;
                    end
                end
                // let the in-flight pixels reach memory
                ST_DRAIN: begin
                    if (vld_d == 3'b000) begin
                        state <= ST_DONE;
                        busy  <= 1'b0;
                        done  <= 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // read address becomes the write address three edges later
    always_ff @(posedge clk_i) begin
        addr_d[0] <= rd_addr_q;
        addr_d[1] <= addr_d[0];
        addr_d[2] <= addr_d[1];
    end

    assign mem.rd_addr = rd_addr_q;
    assign mem.wr_addr = addr_d[2];
    assign mem.we      = vld_d[2];

endmodule

`default_nettype wire

//--- hw/filter_engine/pixel_transform.sv
// ------------------------------
// pixel transform
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module pixel_transform import pix_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_i,
    input  filt_op_e op,
    input  pixel_t   pix_in,
    output pixel_t   pix_out
);

    pixel_t     pix_q;
    logic [5:0] sum;
    logic [3:0] gray;

    // pipeline register behind the RAM output
    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            pix_q <= '0;
        end else begin
            pix_q <= pix_in;
        end
    end

    always_comb begin
        sum  = {2'b00, pix_q[11:8]} + {2'b00, pix_q[7:4]} + {2'b00, pix_q[3:0]};
        // sum / 4, never above 11
        gray = sum[5:2];
        case (op)
            OP_GRAY:   pix_out = {gray, gray, gray};
            // 15 - x per nibble
            OP_INVERT: pix_out = ~pix_q;
            OP_PASS:   pix_out = pix_q;
            default:   pix_out = pix_q;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/frame_buffer/frame_buffer.sv
// ------------------------------
// frame buffer RAM
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "pix_settings.svh"

module frame_buffer import pix_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_i,
    input  logic      busy,
    pix_mem_if.memory eng,
    pix_mem_if.memory host
);

    pixel_t    mem [`FRAME_PIXELS];
    pix_addr_t rd_addr_q;
    pixel_t    rd_data_q;
    pix_addr_t wr_addr;
    pixel_t    wr_data;
    logic      we;

    // engine owns both ports for the whole pass
    always_comb begin
        wr_addr = busy ? eng.wr_addr : host.wr_addr;
        wr_data = busy ? eng.wr_data : host.wr_data;
        we      = busy ? eng.we      : host.we;
    end

    // address stage
    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            rd_addr_q <= '0;
        end else begin
            rd_addr_q <= busy ? eng.rd_addr : host.rd_addr;
        end
    end

    // write port and registered read output, read before write
    always_ff @(posedge clk_i) begin
        if (we) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data_q <= mem[rd_addr_q];
    end

    assign eng.rd_data  = rd_data_q;
    assign host.rd_data = rd_data_q;

endmodule

`default_nettype wire

//--- hw/image_filter_top.sv
// ------------------------------
// image filter top
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module image_filter_top import pix_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [4:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    logic      start;
    logic      busy;
    logic      done;
    pix_addr_t count;
    filt_op_e  op;

    pix_mem_if eng_mem ();
    pix_mem_if host_mem ();

    apb_regs u_regs (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .start   (start),
        .count   (count),
        .op      (op),
        .busy    (busy),
        .done    (done),
        .host    (host_mem)
    );

    filter_sequencer u_seq (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .start (start),
        .count (count),
        .busy  (busy),
        .done  (done),
        .mem   (eng_mem)
    );

    // transform sits between the engine's read data and write data
    pixel_transform u_xform (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .op      (op),
        .pix_in  (eng_mem.rd_data),
        .pix_out (eng_mem.wr_data)
    );

    frame_buffer u_fb (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .busy  (busy),
        .eng   (eng_mem),
        .host  (host_mem)
    );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary --timing -Wno-fatal --top-module tb_image_filter -f compile.f \
    && ./obj_dir/Vtb_image_filter \
    || exit 1
